/* wg_pkg.sv */
`default_nettype none

package wg_pkg;

  // Sizing of the transaction tracking
  localparam int unsigned NumTxns    = 4;
  localparam int unsigned NumIdSlots = 4;

  // Channel field widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 8;
  localparam int unsigned CntWidth  = 8;

  typedef logic [IdWidth-1:0]            id_t;
  typedef logic [AddrWidth-1:0]          addr_t;
  typedef logic [DataWidth-1:0]          data_t;
  typedef logic [LenWidth-1:0]           len_t;
  typedef logic [CntWidth-1:0]           cnt_t;
  typedef logic [$clog2(NumTxns)-1:0]    txn_idx_t;
  typedef logic [$clog2(NumIdSlots)-1:0] slot_idx_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } b_chan_t;

  // Master-driven half of the write bus
  typedef struct packed {
    logic     aw_valid;
    aw_chan_t aw;
    logic     w_valid;
    w_chan_t  w;
    logic     b_ready;
  } axi_wr_req_t;

  // Slave-driven half of the write bus
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
  } axi_wr_rsp_t;

  // Cycle budgets, one per watched interval
  typedef struct packed {
    cnt_t aw_stall;
    cnt_t aw_to_wfirst;
    cnt_t wfirst_to_wlast;
    cnt_t wlast_to_b;
  } budgets_t;

  // Handshake facts of the current cycle, as seen by the master
  typedef struct packed {
    logic aw_hs;
    logic aw_pending;
    id_t  aw_id;
    logic w_hs;
    logic w_last;
    logic b_hs;
    id_t  b_id;
  } wr_events_t;

  typedef enum logic [1:0] {
    PH_FREE,
    PH_WAIT_W,
    PH_DATA,
    PH_RESP
  } phase_e;

  typedef enum logic [2:0] {
    FC_NONE,
    FC_AW_STALL,
    FC_W_LATE,
    FC_W_SLOW,
    FC_B_LATE,
    FC_B_UNEXPECTED
  } fault_cause_e;

  typedef struct packed {
    fault_cause_e cause;
    id_t          id;
  } fault_info_t;

endpackage

`default_nettype wire

/* wg_channel_gate.sv */
`default_nettype none

module wg_channel_gate (
  input  logic                 guard_ena_i,
  input  logic                 isolate_i,
  input  logic                 full_i,
  input  wg_pkg::axi_wr_req_t  mst_req_i,
  input  wg_pkg::axi_wr_rsp_t  slv_rsp_i,
  output wg_pkg::axi_wr_req_t  slv_req_o,
  output wg_pkg::axi_wr_rsp_t  mst_rsp_o,
  output wg_pkg::wr_events_t   events_o
);

  always_comb begin
    // Straight copy unless the guard steps in
    slv_req_o = mst_req_i;
    mst_rsp_o = slv_rsp_i;

    if (guard_ena_i) begin
      if (isolate_i) begin
        // Master sees every beat accepted, slave sees nothing new
        slv_req_o.aw_valid = 1'b0;
        slv_req_o.w_valid  = 1'b0;
        mst_rsp_o.aw_ready = 1'b1;
        mst_rsp_o.w_ready  = 1'b1;
        mst_rsp_o.b_valid  = 1'b0;
        // Drain whatever the slave still has queued on B
        slv_req_o.b_ready  = 1'b1;
      end else if (full_i) begin
        // No free entry to track another write
        slv_req_o.aw_valid = 1'b0;
        mst_rsp_o.aw_ready = 1'b0;
      end
    end
  end

  // Handshakes are taken from the gated master-side view
  always_comb begin
    events_o = '0;
    if (guard_ena_i && !isolate_i) begin
      events_o.aw_hs      = mst_req_i.aw_valid && mst_rsp_o.aw_ready;
      events_o.aw_pending = mst_req_i.aw_valid;
      events_o.aw_id      = mst_req_i.aw.id;
      events_o.w_hs       = mst_req_i.w_valid && mst_rsp_o.w_ready;
      events_o.w_last     = mst_req_i.w.last;
      events_o.b_hs       = mst_rsp_o.b_valid && mst_req_i.b_ready;
      events_o.b_id       = mst_rsp_o.b.id;
    end
  end

endmodule

`default_nettype wire

/* wg_id_table.sv */
`default_nettype none

module wg_id_table (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  wg_pkg::wr_events_t                    events_i,
  input  wg_pkg::phase_e [wg_pkg::NumTxns-1:0]  phase_i,
  output logic                                  full_o,
  output wg_pkg::txn_idx_t                      alloc_idx_o,
  output logic                                  b_hit_o,
  output wg_pkg::txn_idx_t                      b_head_idx_o
);

  // One slot per live ID, pointing at the oldest and youngest entry
  typedef struct packed {
    wg_pkg::id_t      id;
    wg_pkg::txn_idx_t head;
    wg_pkg::txn_idx_t tail;
    logic             free;
  } head_tail_t;

  typedef struct packed {
    wg_pkg::txn_idx_t next;
    logic             free;
  } pool_entry_t;

  head_tail_t  [wg_pkg::NumIdSlots-1:0] slot_d, slot_q;
  pool_entry_t [wg_pkg::NumTxns-1:0]    pool_d, pool_q;

  logic              b_match;
  wg_pkg::slot_idx_t b_slot;
  wg_pkg::txn_idx_t  head_idx;
  logic              aw_match;
  wg_pkg::slot_idx_t aw_slot;
  wg_pkg::slot_idx_t free_slot;
  wg_pkg::txn_idx_t  free_idx;

  // Lookup of the B ID, lowest matching slot
  always_comb begin
    b_match = 1'b0;
    b_slot  = '0;
    for (int i = wg_pkg::NumIdSlots - 1; i >= 0; i--) begin
      if (!slot_q[i].free && (slot_q[i].id == events_i.b_id)) begin
        b_match = 1'b1;
        b_slot  = wg_pkg::slot_idx_t'(i);
      end
    end
  end

  assign head_idx     = slot_q[b_slot].head;
  assign b_head_idx_o = head_idx;
  // Only a head already waiting for its response may retire
  assign b_hit_o      = events_i.b_hs && b_match && (phase_i[head_idx] == wg_pkg::PH_RESP);

  always_comb begin
    full_o = 1'b1;
    for (int i = 0; i < wg_pkg::NumTxns; i++) begin
      if (pool_q[i].free) begin
        full_o = 1'b0;
      end
    end
  end

  always_comb begin
    slot_d    = slot_q;
    pool_d    = pool_q;
    aw_match  = 1'b0;
    aw_slot   = '0;
    free_slot = '0;
    free_idx  = '0;

    if (b_hit_o) begin
      pool_d[head_idx].free = 1'b1;
      if (slot_q[b_slot].head == slot_q[b_slot].tail) begin
        slot_d[b_slot].free = 1'b1;
      end else begin
        slot_d[b_slot].head = pool_q[head_idx].next;
      end
    end

    // Searching the post-pop state covers all reuse cases at once:
    // a reopened slot for the same ID, a freed slot for a new ID, a freed entry
    for (int i = wg_pkg::NumIdSlots - 1; i >= 0; i--) begin
      if (!slot_d[i].free && (slot_d[i].id == events_i.aw_id)) begin
        aw_match = 1'b1;
        aw_slot  = wg_pkg::slot_idx_t'(i);
      end
      if (slot_d[i].free) begin
        free_slot = wg_pkg::slot_idx_t'(i);
      end
    end
    for (int i = wg_pkg::NumTxns - 1; i >= 0; i--) begin
      if (pool_d[i].free) begin
        free_idx = wg_pkg::txn_idx_t'(i);
      end
    end

    if (events_i.aw_hs) begin
      pool_d[free_idx].free = 1'b0;
      pool_d[free_idx].next = '0;
      if (aw_match) begin
        // Append behind the youngest write of this ID
        pool_d[slot_d[aw_slot].tail].next = free_idx;
        slot_d[aw_slot].tail              = free_idx;
      end else begin
        slot_d[free_slot] = '{id: events_i.aw_id, head: free_idx, tail: free_idx, free: 1'b0};
      end
    end
  end

  assign alloc_idx_o = free_idx;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < wg_pkg::NumIdSlots; i++) begin
        slot_q[i] <= '{free: 1'b1, default: '0};
      end
      for (int i = 0; i < wg_pkg::NumTxns; i++) begin
        pool_q[i] <= '{free: 1'b1, default: '0};
      end
    end else if (flush_i) begin
      for (int i = 0; i < wg_pkg::NumIdSlots; i++) begin
        slot_q[i] <= '{free: 1'b1, default: '0};
      end
      for (int i = 0; i < wg_pkg::NumTxns; i++) begin
        pool_q[i] <= '{free: 1'b1, default: '0};
      end
    end else begin
      slot_q <= slot_d;
      pool_q <= pool_d;
    end
  end

endmodule

`default_nettype wire

/* wg_txn_timers.sv */
`default_nettype none

module wg_txn_timers (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  wg_pkg::budgets_t                      budgets_i,
  input  wg_pkg::wr_events_t                    events_i,
  input  wg_pkg::txn_idx_t                      alloc_idx_i,
  input  logic                                  b_hit_i,
  input  wg_pkg::txn_idx_t                      b_head_idx_i,
  output wg_pkg::phase_e [wg_pkg::NumTxns-1:0]  phase_o,
  output logic                                  timeout_o,
  output wg_pkg::fault_cause_e                  timeout_cause_o,
  output wg_pkg::id_t                           timeout_id_o
);

  wg_pkg::phase_e   [wg_pkg::NumTxns-1:0] phase_d, phase_q;
  wg_pkg::cnt_t     [wg_pkg::NumTxns-1:0] cnt_q;
  wg_pkg::id_t      [wg_pkg::NumTxns-1:0] id_q;
  wg_pkg::txn_idx_t [wg_pkg::NumTxns-1:0] wq_mem;

  wg_pkg::txn_idx_t              wq_rd_q, wq_wr_q;
  logic [$clog2(wg_pkg::NumTxns):0] wq_cnt_q;
  logic                          wq_empty;
  logic                          wq_push;
  logic                          wq_pop;
  logic                          w_take;
  logic                          w_done;
  wg_pkg::txn_idx_t              w_idx;

  function automatic wg_pkg::cnt_t phase_budget(input wg_pkg::phase_e ph,
                                                input wg_pkg::budgets_t b);
    wg_pkg::cnt_t lim;
    case (ph)
      wg_pkg::PH_WAIT_W: lim = b.aw_to_wfirst;
      wg_pkg::PH_DATA:   lim = b.wfirst_to_wlast;
      default:           lim = b.wlast_to_b;
    endcase
    return lim;
  endfunction

  // W carries no ID, so beats go to the oldest write still owed data.
  // An AW accepted in the same cycle as its first beat bypasses the queue
  assign wq_empty = (wq_cnt_q == '0);
  assign w_idx    = wq_empty ? alloc_idx_i : wq_mem[wq_rd_q];
  assign w_take   = events_i.w_hs && (!wq_empty || events_i.aw_hs);
  assign w_done   = w_take && events_i.w_last;
  assign wq_push  = events_i.aw_hs && !(wq_empty && w_done);
  assign wq_pop   = w_done && !wq_empty;

  always_comb begin
    phase_d = phase_q;
    for (int i = 0; i < wg_pkg::NumTxns; i++) begin
      if (b_hit_i && (b_head_idx_i == wg_pkg::txn_idx_t'(i))) begin
        phase_d[i] = wg_pkg::PH_FREE;
      end
      if (events_i.aw_hs && (alloc_idx_i == wg_pkg::txn_idx_t'(i))) begin
        phase_d[i] = wg_pkg::PH_WAIT_W;
      end
      if (w_take && (w_idx == wg_pkg::txn_idx_t'(i))) begin
        if (events_i.w_last) begin
          phase_d[i] = wg_pkg::PH_RESP;
        end else if (phase_d[i] == wg_pkg::PH_WAIT_W) begin
          phase_d[i] = wg_pkg::PH_DATA;
        end
      end
    end
  end

  // Lowest busy entry over its budget wins
  always_comb begin
    timeout_o       = 1'b0;
    timeout_cause_o = wg_pkg::FC_NONE;
    timeout_id_o    = '0;
    for (int i = wg_pkg::NumTxns - 1; i >= 0; i--) begin
      if ((phase_q[i] != wg_pkg::PH_FREE) &&
          (cnt_q[i] >= phase_budget(phase_q[i], budgets_i))) begin
        timeout_o    = 1'b1;
        timeout_id_o = id_q[i];
        case (phase_q[i])
          wg_pkg::PH_WAIT_W: timeout_cause_o = wg_pkg::FC_W_LATE;
          wg_pkg::PH_DATA:   timeout_cause_o = wg_pkg::FC_W_SLOW;
          default:           timeout_cause_o = wg_pkg::FC_B_LATE;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q  <= {wg_pkg::NumTxns{wg_pkg::PH_FREE}};
      cnt_q    <= '0;
      wq_rd_q  <= '0;
      wq_wr_q  <= '0;
      wq_cnt_q <= '0;
    end else if (flush_i) begin
      phase_q  <= {wg_pkg::NumTxns{wg_pkg::PH_FREE}};
      cnt_q    <= '0;
      wq_rd_q  <= '0;
      wq_wr_q  <= '0;
      wq_cnt_q <= '0;
    end else begin
      phase_q <= phase_d;
      for (int i = 0; i < wg_pkg::NumTxns; i++) begin
        // Restart on every phase change and saturate at the top
        if ((phase_d[i] != phase_q[i]) || (phase_q[i] == wg_pkg::PH_FREE)) begin
          cnt_q[i] <= '0;
        end else if (cnt_q[i] != '1) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
      if (wq_push) begin
        wq_wr_q <= wq_wr_q + 1'b1;
      end
      if (wq_pop) begin
        wq_rd_q <= wq_rd_q + 1'b1;
      end
      if (wq_push && !wq_pop) begin
        wq_cnt_q <= wq_cnt_q + 1'b1;
      end else if (!wq_push && wq_pop) begin
        wq_cnt_q <= wq_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (events_i.aw_hs) begin
      id_q[alloc_idx_i] <= events_i.aw_id;
    end
    if (wq_push) begin
      wq_mem[wq_wr_q] <= alloc_idx_i;
    end
  end

  assign phase_o = phase_q;

endmodule

`default_nettype wire

/* wg_fault_ctrl.sv */
`default_nettype none

module wg_fault_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  wg_pkg::budgets_t      budgets_i,
  input  wg_pkg::wr_events_t    events_i,
  input  logic                  timeout_i,
  input  wg_pkg::fault_cause_e  timeout_cause_i,
  input  wg_pkg::id_t           timeout_id_i,
  input  logic                  b_hit_i,
  output logic                  isolate_o,
  output logic                  flush_o,
  output logic                  reset_req_o,
  output logic                  irq_o,
  output wg_pkg::fault_info_t   fault_o
);

  wg_pkg::cnt_t        aw_cnt_q;
  logic                aw_stall;
  logic                b_unexp;
  logic                new_fault;
  wg_pkg::fault_info_t new_info;
  logic                faulted_q;
  logic                irq_q;
  wg_pkg::fault_info_t fault_q;

  // Only one AW can wait at the master port, so one counter covers it
  assign aw_stall = events_i.aw_pending && !events_i.aw_hs &&
                    (aw_cnt_q >= budgets_i.aw_stall);
  assign b_unexp  = events_i.b_hs && !b_hit_i;

  always_comb begin
    new_fault = 1'b1;
    new_info  = '{cause: wg_pkg::FC_NONE, id: '0};
    if (b_unexp) begin
      new_info = '{cause: wg_pkg::FC_B_UNEXPECTED, id: events_i.b_id};
    end else if (timeout_i) begin
      new_info = '{cause: timeout_cause_i, id: timeout_id_i};
    end else if (aw_stall) begin
      new_info = '{cause: wg_pkg::FC_AW_STALL, id: events_i.aw_id};
    end else begin
      new_fault = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_cnt_q <= '0;
    end else if (flush_o || !events_i.aw_pending || events_i.aw_hs) begin
      aw_cnt_q <= '0;
    end else if (aw_cnt_q != '1) begin
      aw_cnt_q <= aw_cnt_q + 1'b1;
    end
  end

  // First fault sticks until clear, later ones are ignored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      faulted_q <= 1'b0;
      irq_q     <= 1'b0;
      fault_q   <= '{cause: wg_pkg::FC_NONE, id: '0};
    end else begin
      irq_q <= 1'b0;
      if (clear_i) begin
        faulted_q <= 1'b0;
        fault_q   <= '{cause: wg_pkg::FC_NONE, id: '0};
      end else if (!faulted_q && new_fault) begin
        faulted_q <= 1'b1;
        irq_q     <= 1'b1;
        fault_q   <= new_info;
      end
    end
  end

  // Clear empties the table on the same edge the fault drops
  assign flush_o     = clear_i;
  assign isolate_o   = faulted_q;
  assign reset_req_o = faulted_q;
  assign irq_o       = irq_q;
  assign fault_o     = fault_q;

endmodule

`default_nettype wire

/* write_guard.sv */
`default_nettype none

module write_guard (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 guard_ena_i,
  input  logic                 clear_i,
  input  wg_pkg::budgets_t     budgets_i,
  input  wg_pkg::axi_wr_req_t  mst_req_i,
  output wg_pkg::axi_wr_rsp_t  mst_rsp_o,
  output wg_pkg::axi_wr_req_t  slv_req_o,
  input  wg_pkg::axi_wr_rsp_t  slv_rsp_i,
  output logic                 reset_req_o,
  output logic                 irq_o,
  output wg_pkg::fault_info_t  fault_o
);

  wg_pkg::wr_events_t                    events;
  logic                                  full;
  wg_pkg::txn_idx_t                      alloc_idx;
  logic                                  b_hit;
  wg_pkg::txn_idx_t                      b_head_idx;
  wg_pkg::phase_e [wg_pkg::NumTxns-1:0]  phase;
  logic                                  timeout;
  wg_pkg::fault_cause_e                  timeout_cause;
  wg_pkg::id_t                           timeout_id;
  logic                                  isolate;
  logic                                  flush;

  wg_channel_gate u_gate (
    .guard_ena_i (guard_ena_i),
    .isolate_i   (isolate),
    .full_i      (full),
    .mst_req_i   (mst_req_i),
    .slv_rsp_i   (slv_rsp_i),
    .slv_req_o   (slv_req_o),
    .mst_rsp_o   (mst_rsp_o),
    .events_o    (events)
  );

  wg_id_table u_table (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush),
    .events_i     (events),
    .phase_i      (phase),
    .full_o       (full),
    .alloc_idx_o  (alloc_idx),
    .b_hit_o      (b_hit),
    .b_head_idx_o (b_head_idx)
  );

  wg_txn_timers u_timers (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush),
    .budgets_i       (budgets_i),
    .events_i        (events),
    .alloc_idx_i     (alloc_idx),
    .b_hit_i         (b_hit),
    .b_head_idx_i    (b_head_idx),
    .phase_o         (phase),
    .timeout_o       (timeout),
    .timeout_cause_o (timeout_cause),
    .timeout_id_o    (timeout_id)
  );

  wg_fault_ctrl u_fault (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .budgets_i       (budgets_i),
    .events_i        (events),
    .timeout_i       (timeout),
    .timeout_cause_i (timeout_cause),
    .timeout_id_i    (timeout_id),
    .b_hit_i         (b_hit),
    .isolate_o       (isolate),
    .flush_o         (flush),
    .reset_req_o     (reset_req_o),
    .irq_o           (irq_o),
    .fault_o         (fault_o)
  );

endmodule

`default_nettype wire

/* tb_write_guard.sv */
`default_nettype none

module tb_write_guard;

  localparam int MaxTests = 32;
  localparam int MaxTxns  = 5;
  localparam int Period   = 8;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 guard_ena;
  logic                 clear;
  wg_pkg::budgets_t     budgets;
  wg_pkg::axi_wr_req_t  mst_req;
  wg_pkg::axi_wr_rsp_t  mst_rsp;
  wg_pkg::axi_wr_req_t  slv_req;
  wg_pkg::axi_wr_rsp_t  slv_rsp;
  logic                 reset_req;
  logic                 irq;
  wg_pkg::fault_info_t  fault;

  int               ntests;
  int               errors;
  int               tests_failed;
  logic [31:0]      lcg_state;
  logic             limit_ready = 1'b0;
  longint           limit;
  wg_pkg::budgets_t bud_a [MaxTests];
  int               ena_a [MaxTests];
  int               ntxn_a [MaxTests];
  wg_pkg::id_t      ids_a [MaxTests][MaxTxns];
  int               wdel_a [MaxTests];
  int               wgap_a [MaxTests];
  int               bdel_a [MaxTests];
  int               bbad_a [MaxTests];
  int               ecause_a [MaxTests];
  int               eid_a [MaxTests];

  write_guard u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .guard_ena_i (guard_ena),
    .clear_i     (clear),
    .budgets_i   (budgets),
    .mst_req_i   (mst_req),
    .mst_rsp_o   (mst_rsp),
    .slv_req_o   (slv_req),
    .slv_rsp_i   (slv_rsp),
    .reset_req_o (reset_req),
    .irq_o       (irq),
    .fault_o     (fault)
  );

  initial clk_i = 1'b0;
  always #(Period / 2) clk_i = ~clk_i;

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bound on the length of one test in cycles
  function automatic int test_cycles(input int t);
    return ntxn_a[t] * (wdel_a[t] + 2 * wgap_a[t] + bdel_a[t] + 10) + 60;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  task automatic load_tests();
    int    fd;
    int    n;
    int    v [17];
    string line;
    ntests = 0;
    fd = $fopen("write_guard_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open write_guard_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && ntests < MaxTests) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                      v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
          if (n != 17 || v[5] < 1 || v[5] > MaxTxns) begin
            $display("Malformed line in the test file: %s", line);
            errors++;
          end else begin
            bud_a[ntests].aw_stall        = wg_pkg::cnt_t'(v[0]);
            bud_a[ntests].aw_to_wfirst    = wg_pkg::cnt_t'(v[1]);
            bud_a[ntests].wfirst_to_wlast = wg_pkg::cnt_t'(v[2]);
            bud_a[ntests].wlast_to_b      = wg_pkg::cnt_t'(v[3]);
            ena_a[ntests]  = v[4];
            ntxn_a[ntests] = v[5];
            for (int k = 0; k < MaxTxns; k++) begin
              ids_a[ntests][k] = wg_pkg::id_t'(v[6 + k]);
            end
            wdel_a[ntests]   = v[11];
            wgap_a[ntests]   = v[12];
            bdel_a[ntests]   = v[13];
            bbad_a[ntests]   = v[14];
            ecause_a[ntests] = v[15];
            eid_a[ntests]    = v[16];
            ntests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Master issues AWs back to back and two-beat W bursts in AW order
  // Slave accepts at once and returns B in order after the B delay
  task automatic run_test(input int t);
    wg_pkg::axi_wr_req_t nreq;
    wg_pkg::axi_wr_rsp_t nrsp;
    wg_pkg::id_t         aw_ids [$];
    wg_pkg::id_t         b_ids [$];
    logic [1:0]          b_resps [$];
    int                  b_times [$];
    logic [1:0]          resp_exp [MaxTxns];
    logic [31:0]         rnd;
    wg_pkg::id_t         sid;
    int                  cyc, cap, aw_acc, b_recv, wl_cnt, w_txn, w_beat, w_wait;
    int                  irq_cnt, post, stalls, err_start;
    logic                aw_hs, w_hs, b_hs, s_aw, s_w, s_b;
    logic                faulted, w_armed, fault_exp, done;
    err_start = errors;
    fault_exp = (ecause_a[t] != 0);
    cap = test_cycles(t);
    cyc = 0;
    aw_acc = 0;
    b_recv = 0;
    wl_cnt = 0;
    w_txn = 0;
    w_beat = 0;
    w_wait = 0;
    irq_cnt = 0;
    post = 0;
    stalls = 0;
    faulted = 1'b0;
    w_armed = 1'b0;
    done = 1'b0;
    for (int k = 0; k < MaxTxns; k++) begin
      rnd         = next_rand();
      resp_exp[k] = rnd[31:30];
    end
    nreq = '0;
    nreq.b_ready  = 1'b1;
    nreq.aw_valid = 1'b1;
    nreq.aw.id    = ids_a[t][0];
    nreq.aw.addr  = next_rand();
    nreq.aw.len   = wg_pkg::len_t'(1);
    @(posedge clk_i);
    guard_ena <= (ena_a[t] != 0);
    budgets   <= bud_a[t];
    mst_req   <= nreq;

    while (!done) begin
      @(negedge clk_i);
      cyc++;
      aw_hs = mst_req.aw_valid && mst_rsp.aw_ready;
      w_hs  = mst_req.w_valid && mst_rsp.w_ready;
      b_hs  = mst_rsp.b_valid && mst_req.b_ready;
      s_aw  = slv_req.aw_valid && slv_rsp.aw_ready;
      s_w   = slv_req.w_valid && slv_rsp.w_ready;
      s_b   = slv_rsp.b_valid && slv_req.b_ready;
      nreq  = mst_req;
      nrsp  = slv_rsp;
      if (irq) begin
        irq_cnt++;
      end
      if (!guard_ena) begin
        check_value("slv_req_o", slv_req, mst_req);
        check_value("mst_rsp_o", mst_rsp, slv_rsp);
      end
      if (!fault_exp) begin
        check_value("reset_req_o", reset_req, 1'b0);
      end

      if (faulted) begin
        // Isolation hides the busy slave and accepts every master beat
        check_value("reset_req_o", reset_req, 1'b1);
        check_value("slv_req_o.aw_valid", slv_req.aw_valid, 1'b0);
        check_value("slv_req_o.w_valid", slv_req.w_valid, 1'b0);
        check_value("mst_rsp_o.aw_ready", mst_rsp.aw_ready, 1'b1);
        check_value("mst_rsp_o.w_ready", mst_rsp.w_ready, 1'b1);
        check_value("mst_rsp_o.b_valid", mst_rsp.b_valid, 1'b0);
        post++;
        done = (post >= 6);
      end else if (reset_req) begin
        faulted = 1'b1;
      end

      if (faulted) begin
        // Master keeps pushing while the slave stalls and offers a B
        nreq.aw_valid = 1'b1;
        nreq.w_valid  = 1'b1;
        nrsp.aw_ready = 1'b0;
        nrsp.w_ready  = 1'b0;
        nrsp.b_valid  = 1'b1;
      end else begin
        if (guard_ena && mst_req.aw_valid && (aw_acc - b_recv >= int'(wg_pkg::NumTxns))) begin
          check_value("mst_rsp_o.aw_ready", mst_rsp.aw_ready, 1'b0);
        end
        if (mst_req.aw_valid && !mst_rsp.aw_ready) begin
          stalls++;
        end
        if (aw_hs) begin
          aw_acc++;
          nreq.aw_valid = (aw_acc < ntxn_a[t]);
          if (aw_acc < ntxn_a[t]) begin
            nreq.aw.id   = ids_a[t][aw_acc];
            nreq.aw.addr = next_rand();
          end
        end
        if (w_hs) begin
          w_beat++;
          nreq.w_valid = 1'b0;
          if (mst_req.w.last) begin
            w_txn++;
            w_beat  = 0;
            w_armed = 1'b0;
          end else begin
            w_wait = wgap_a[t];
          end
        end
        // A burst only starts once its AW has been taken
        if (!nreq.w_valid && (w_txn < aw_acc)) begin
          if (!w_armed) begin
            w_armed = 1'b1;
            w_wait  = wdel_a[t];
          end
          if (w_wait > 0) begin
            w_wait--;
          end else begin
            nreq.w_valid  = 1'b1;
            nreq.w.data   = next_rand();
            nreq.w.last   = (w_beat == 1);
          end
        end
        if (b_hs) begin
          check_value("mst_rsp_o.b.id", mst_rsp.b.id,
                      (bbad_a[t] != 0) ? 4'hf : ids_a[t][b_recv]);
          check_value("mst_rsp_o.b.resp", mst_rsp.b.resp, resp_exp[b_recv]);
          b_recv++;
        end

        if (s_aw) begin
          aw_ids.push_back(slv_req.aw.id);
        end
        if (s_w && slv_req.w.last) begin
          if (aw_ids.size() == 0) begin
            $display("Slave saw a last W beat without a matching AW at %0t", $time);
            errors++;
            sid = '0;
          end else begin
            sid = aw_ids.pop_front();
          end
          b_ids.push_back((bbad_a[t] != 0) ? 4'hf : sid);
          b_resps.push_back(resp_exp[wl_cnt]);
          b_times.push_back(cyc + bdel_a[t]);
          wl_cnt++;
        end
        if (s_b) begin
          void'(b_ids.pop_front());
          void'(b_resps.pop_front());
          void'(b_times.pop_front());
        end
        nrsp.b_valid = 1'b0;
        if ((b_ids.size() > 0) && (cyc >= b_times[0])) begin
          nrsp.b_valid  = 1'b1;
          nrsp.b.id     = b_ids[0];
          nrsp.b.resp   = b_resps[0];
        end
        if (!fault_exp && (b_recv == ntxn_a[t])) begin
          done = 1'b1;
        end
      end

      if (!done && (cyc > cap)) begin
        $display("Test %0d did not finish within %0d cycles", t, cap);
        errors++;
        done = 1'b1;
      end
      @(posedge clk_i);
      mst_req <= nreq;
      slv_rsp <= nrsp;
    end

    @(negedge clk_i);
    if (fault_exp) begin
      check_value("fault_o.cause", fault.cause, ecause_a[t]);
      check_value("fault_o.id", fault.id, eid_a[t]);
      check_value("irq_o pulse count", irq_cnt, 1);
    end else begin
      check_value("fault_o.cause", fault.cause, wg_pkg::FC_NONE);
      check_value("irq_o pulse count", irq_cnt, 0);
      if (guard_ena && (ntxn_a[t] > int'(wg_pkg::NumTxns)) && (stalls == 0)) begin
        $display("Test %0d: the extra AW was never held back by the full table", t);
        errors++;
      end
    end

    // Return both sides to idle and clear the guard
    nreq = '0;
    nreq.b_ready = 1'b1;
    nrsp = '0;
    nrsp.aw_ready = 1'b1;
    nrsp.w_ready  = 1'b1;
    @(posedge clk_i);
    mst_req <= nreq;
    slv_rsp <= nrsp;
    clear   <= 1'b1;
    @(posedge clk_i);
    clear   <= 1'b0;
    @(negedge clk_i);
    check_value("reset_req_o", reset_req, 1'b0);
    check_value("fault_o.cause", fault.cause, wg_pkg::FC_NONE);
    if (errors != err_start) begin
      tests_failed++;
    end
    $display("test %0d: %s, %0d cycles", t, (errors == err_start) ? "ok" : "mismatch", cyc);
  endtask

  initial begin
    wait (limit_ready);
    #(limit);
    $display("Watchdog expired at %0t, the run did not finish", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    errors       = 0;
    tests_failed = 0;
    lcg_state    = 32'hc50a;
    rst_ni       = 1'b0;
    guard_ena    = 1'b0;
    clear        = 1'b0;
    budgets      = '0;
    mst_req      = '0;
    slv_rsp      = '0;
    slv_rsp.aw_ready = 1'b1;
    slv_rsp.w_ready  = 1'b1;

    load_tests();
    limit = 100;
    for (int t = 0; t < ntests; t++) begin
      limit += test_cycles(t) + 20;
    end
    limit = limit * Period;
    limit_ready = 1'b1;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("reset_req_o", reset_req, 1'b0);
    check_value("irq_o", irq, 1'b0);
    check_value("fault_o.cause", fault.cause, wg_pkg::FC_NONE);

    for (int t = 0; t < ntests; t++) begin
      run_test(t);
    end
    if (ntests == 0) begin
      $display("No tests were loaded");
      errors++;
    end

    $display("%0d tests run, %0d failed, %0d errors", ntests, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* write_guard_tests.txt */
# aw_stall aw_wfirst wfirst_wlast wlast_b ena ntxn id0 id1 id2 id3 id4 w_delay w_gap b_delay b_bad
# exp_cause exp_id  (cause 0 none, 1 aw stall, 2 w late, 3 w slow, 4 b late, 5 b unexpected)
5   5   5   5   0 3 1 2 1 0  0 120 20 150 0 0 0
5   5   5   5   0 2 4 6 0 0  0 1   0  2   1 0 0
60  60  60  60  1 4 1 2 1 3  0 1   0  2   0 0 0
60  60  60  60  1 3 5 5 5 0  0 4   3  6   0 0 0
200 10  200 200 1 1 6 0 0 0  0 80  0  2   0 2 6
60  60  60  60  1 2 2 7 0 0  0 1   1  3   0 0 0
200 200 10  200 1 1 7 0 0 0  0 1   60 2   0 3 7
60  60  60  60  1 3 3 4 3 0  0 2   0  4   0 0 0
200 200 200 10  1 2 2 9 0 0  0 1   0  90  0 4 2
200 200 200 200 1 1 3 0 0 0  0 1   0  3   1 5 15
250 200 200 200 1 5 1 2 1 3  2 1   0  30  0 0 0
8   200 200 200 1 5 1 2 3 4  5 1   0  60  0 1 5
60  60  60  60  1 4 8 9 8 10 0 2   1  4   0 0 0

/* write_guard.f */
wg_pkg.sv
wg_channel_gate.sv
wg_id_table.sv
wg_txn_timers.sv
wg_fault_ctrl.sv
write_guard.sv
tb_write_guard.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the write guard testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_write_guard \
  -f write_guard.f -o tb_write_guard
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_write_guard | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi
